/* logic/mont_pkg.sv */
`default_nettype none

package mont_pkg;

    // Operand width, everything else follows from it
    localparam int OPERAND_W = 64;

    // Room for 3b + 3m plus carry and sign
    localparam int ACC_W = OPERAND_W + 3;

    // Radix-4 steps per multiplication
    localparam int DIGIT_COUNT = OPERAND_W / 2;
    localparam int DIGIT_CNT_W = $clog2(DIGIT_COUNT);

    // Multiples i*b + j*m for i, j in 0..3
    localparam int TABLE_SIZE = 16;

    typedef logic [OPERAND_W-1:0] operand_t;
    typedef logic [ACC_W-1:0] acc_t;

    typedef struct packed {
        logic [1:0] b_digit;
        logic [1:0] m_digit;
    } mult_digits_t;

    // Table index, either as an address or as the two digits
    typedef union packed {
        logic [3:0] index;
        mult_digits_t digits;
    } mult_sel_u;

    typedef enum logic [2:0] {
        IDLE,
        BUILD,
        STEP,
        REDUCE,
        FINISH
    } mont_state_t;

endpackage

`default_nettype wire

/* logic/mult_table_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface mult_table_if;
    import mont_pkg::*;

    // Build request and completion
    logic build;
    logic ready;

    // Digit pair from decode, selected multiple back to the accumulator
    mult_sel_u sel;
    acc_t multiple;

    modport builder (output build, input ready);
    modport index (output sel);
    modport store (input build, input sel, output ready, output multiple);
    modport operand (input multiple);

endinterface

`default_nettype wire

/* logic/mont_control.sv */
`timescale 1ns/10ps
`default_nettype none

module mont_control (
    input  logic clk,
    input  logic resetn,
    input  logic start,
    output logic clear,
    output logic step,
    output logic reduce_go,
    input  logic reduce_done,
    mult_table_if.builder tbl
);
    import mont_pkg::*;

    mont_state_t state;
    logic [DIGIT_CNT_W-1:0] digit_cnt;

    // Operands are captured on the same edge that accepts start
    assign clear = (state == IDLE) && start;
    assign step = (state == STEP);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
            digit_cnt <= '0;
            tbl.build <= 1'b0;
            reduce_go <= 1'b0;
        end else begin
            tbl.build <= 1'b0;
            reduce_go <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= BUILD;
                        digit_cnt <= '0;
                        tbl.build <= 1'b1;
                    end
                end
                BUILD: begin
                    // Ready is still high from the last run while build is up
                    if (tbl.ready && !tbl.build) begin
                        state <= STEP;
                    end
                end
                STEP: begin
                    digit_cnt <= digit_cnt + DIGIT_CNT_W'(1);
                    if (digit_cnt == DIGIT_CNT_W'(DIGIT_COUNT - 1)) begin
                        state <= REDUCE;
                        reduce_go <= 1'b1;
                    end
                end
                REDUCE: begin
                    if (reduce_done) begin
                        state <= FINISH;
                    end
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/digit_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module digit_decode (
    input  logic clk,
    input  logic resetn,
    input  logic clear,
    input  logic step,
    input  mont_pkg::operand_t in_a,
    input  mont_pkg::operand_t in_b,
    input  mont_pkg::operand_t in_m,
    input  logic [1:0] acc_low,
    mult_table_if.index tbl
);
    import mont_pkg::*;

    operand_t a_reg;
    logic [1:0] b_digit;
    logic [1:0] b_part;
    logic [1:0] partial;
    logic [1:0] m_inv;
    mult_sel_u sel;

    // a is consumed two bits per step, low digit first
    always_ff @(posedge clk) begin
        if (!resetn) begin
            a_reg <= '0;
        end else if (clear) begin
            a_reg <= in_a;
        end else if (step) begin
            a_reg <= a_reg >> 2;
        end
    end

    always_comb begin
        b_digit = a_reg[1:0];
        // Everything mod 4, only the low bits of b matter
        b_part = b_digit * in_b[1:0];
        partial = acc_low + b_part;
        // m is odd, so m mod 4 is its own inverse
        m_inv = {in_m[1], 1'b1};
        sel.digits.b_digit = b_digit;
        sel.digits.m_digit = (-partial) * m_inv;
    end

    assign tbl.sel = sel;

endmodule

`default_nettype wire

/* logic/mult_table.sv */
`timescale 1ns/10ps
`default_nettype none

module mult_table (
    input  logic clk,
    input  logic resetn,
    input  mont_pkg::operand_t in_b,
    input  mont_pkg::operand_t in_m,
    mult_table_if.store tbl
);
    import mont_pkg::*;

    // Entry 0 is always zero and never stored
    acc_t entries [1:TABLE_SIZE-1];
    logic filling;
    logic [3:0] wr_idx;
    mult_sel_u fill_sel;
    logic [3:0] base_idx;
    acc_t base;
    acc_t addend;

    always_comb begin
        // Build pulse writes entry 1 on its own edge
        fill_sel.index = tbl.build ? 4'd1 : wr_idx;
        if (fill_sel.digits.m_digit != 2'd0) begin
            base_idx = fill_sel.index - 4'd1;
            addend = acc_t'(in_m);
        end else begin
            base_idx = fill_sel.index - 4'd4;
            addend = acc_t'(in_b);
        end
        base = (base_idx == 4'd0) ? '0 : entries[base_idx];
    end

    always_ff @(posedge clk) begin
        if (tbl.build || filling) begin
            entries[fill_sel.index] <= base + addend;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            filling <= 1'b0;
            wr_idx <= '0;
            tbl.ready <= 1'b0;
        end else if (tbl.build) begin
            filling <= 1'b1;
            wr_idx <= 4'd2;
            tbl.ready <= 1'b0;
        end else if (filling) begin
            wr_idx <= wr_idx + 4'd1;
            if (wr_idx == 4'(TABLE_SIZE - 1)) begin
                filling <= 1'b0;
                tbl.ready <= 1'b1;
            end
        end
    end

    assign tbl.multiple = (tbl.sel.index == 4'd0) ? '0 : entries[tbl.sel.index];

endmodule

`default_nettype wire

/* logic/mont_accumulate.sv */
`timescale 1ns/10ps
`default_nettype none

module mont_accumulate (
    input  logic clk,
    input  logic resetn,
    input  logic clear,
    input  logic step,
    mult_table_if.operand tbl,
    output mont_pkg::acc_t acc,
    output logic [1:0] acc_low
);
    import mont_pkg::*;

    acc_t sum;

    // Stays below 8m, so no carry out of ACC_W
    assign sum = acc + tbl.multiple;

    // Decode picks the m digit so the low two bits of sum are zero
    always_ff @(posedge clk) begin
        if (!resetn) begin
            acc <= '0;
        end else if (clear) begin
            acc <= '0;
        end else if (step) begin
            acc <= sum >> 2;
        end
    end

    assign acc_low = acc[1:0];

endmodule

`default_nettype wire

/* logic/mont_reduce.sv */
`timescale 1ns/10ps
`default_nettype none

module mont_reduce (
    input  logic clk,
    input  logic resetn,
    input  logic reduce_go,
    input  mont_pkg::acc_t acc,
    input  mont_pkg::operand_t in_m,
    output mont_pkg::operand_t result,
    output logic reduce_done
);
    import mont_pkg::*;

    acc_t value;
    acc_t diff;
    acc_t total;
    logic busy;
    logic negative;

    assign diff = value - acc_t'(in_m);
    assign total = value + acc_t'(in_m);
    assign negative = $signed(value) < 0;

    // Subtract m until the sign flips
    always_ff @(posedge clk) begin
        if (reduce_go) begin
            value <= acc;
        end else if (busy && !negative) begin
            value <= diff;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy <= 1'b0;
            result <= '0;
            reduce_done <= 1'b0;
        end else begin
            reduce_done <= 1'b0;
            if (reduce_go) begin
                busy <= 1'b1;
            end else if (busy && negative) begin
                // One add-back lands in the result
                busy <= 1'b0;
                result <= total[OPERAND_W-1:0];
                reduce_done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/mont_mult.sv */
`timescale 1ns/10ps
`default_nettype none

module mont_mult (
    input  logic clk,
    input  logic resetn,
    input  logic start,
    input  logic [mont_pkg::OPERAND_W-1:0] in_a,
    input  logic [mont_pkg::OPERAND_W-1:0] in_b,
    input  logic [mont_pkg::OPERAND_W-1:0] in_m,
    output logic [mont_pkg::OPERAND_W-1:0] result,
    output logic done
);
    import mont_pkg::*;

    logic clear;
    logic step;
    logic reduce_go;
    logic reduce_done;
    acc_t acc;
    logic [1:0] acc_low;

    mult_table_if tbl_if ();

    mont_control mont_control_inst (
        .clk         (clk),
        .resetn      (resetn),
        .start       (start),
        .clear       (clear),
        .step        (step),
        .reduce_go   (reduce_go),
        .reduce_done (reduce_done),
        .tbl         (tbl_if.builder)
    );

    digit_decode digit_decode_inst (
        .clk     (clk),
        .resetn  (resetn),
        .clear   (clear),
        .step    (step),
        .in_a    (in_a),
        .in_b    (in_b),
        .in_m    (in_m),
        .acc_low (acc_low),
        .tbl     (tbl_if.index)
    );

    mult_table mult_table_inst (
        .clk    (clk),
        .resetn (resetn),
        .in_b   (in_b),
        .in_m   (in_m),
        .tbl    (tbl_if.store)
    );

    mont_accumulate mont_accumulate_inst (
        .clk     (clk),
        .resetn  (resetn),
        .clear   (clear),
        .step    (step),
        .tbl     (tbl_if.operand),
        .acc     (acc),
        .acc_low (acc_low)
    );

    mont_reduce mont_reduce_inst (
        .clk         (clk),
        .resetn      (resetn),
        .reduce_go   (reduce_go),
        .acc         (acc),
        .in_m        (in_m),
        .result      (result),
        .reduce_done (reduce_done)
    );

    assign done = reduce_done;

endmodule

`default_nettype wire

/* testbench/mont_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module mont_tb;
    import mont_pkg::*;

    localparam int unsigned SEED = 32'hfa1b811a;
    localparam int RANDOM_RUNS = 20;
    localparam int TEST_COUNT = RANDOM_RUNS + 5;
    localparam int CYCLE_LIMIT = 300 * TEST_COUNT;
    localparam int DRIVE_DELAY = 1;

    logic clk = 1'b0;
    logic resetn;
    logic start;
    operand_t in_a;
    operand_t in_b;
    operand_t in_m;
    operand_t result;
    logic done;

    int cycle_count = 0;
    int check_errors = 0;
    int pass_count = 0;
    int fail_count = 0;
    int done_count = 0;
    int test_errors;
    logic done_prev = 1'b0;
    operand_t held_result = '0;
    operand_t a;
    operand_t b;
    operand_t m;
    operand_t r;

    mont_mult mont_mult_inst (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .result (result),
        .done   (done)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: done never came within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // done must be a single-cycle pulse and result must hold between pulses
    always @(negedge clk) begin
        if (resetn) begin
            if (done) begin
                assert (!done_prev) else begin
                    $display("FAILED at %0t: done high for more than one cycle", $time);
                    check_errors++;
                end
                done_count++;
                held_result = result;
            end else begin
                assert (result == held_result) else begin
                    $display("FAILED at %0t: result changed without done", $time);
                    check_errors++;
                end
            end
            done_prev = done;
        end
    end

    function automatic operand_t random_word();
        return {$urandom, $urandom};
    endfunction

    // result * 2^64 must be congruent to a * b, all mod m
    function automatic logic result_matches(input operand_t a, input operand_t b,
                                            input operand_t m, input operand_t r);
        logic [127:0] wide_m;
        logic [127:0] lhs;
        logic [127:0] rhs;
        wide_m = {64'd0, m};
        lhs = {r, 64'd0} % wide_m;
        rhs = ({64'd0, a} * {64'd0, b}) % wide_m;
        return (r < m) && (lhs == rhs);
    endfunction

    task automatic run_mult(input operand_t a, input operand_t b, input operand_t m,
                            input logic double_start, output operand_t r);
        int dones_before;
        @(posedge clk);
        #DRIVE_DELAY;
        dones_before = done_count;
        in_a = a;
        in_b = b;
        in_m = m;
        start = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        start = 1'b0;
        if (double_start) begin
            repeat (4) @(posedge clk);
            #DRIVE_DELAY;
            // a is already captured, so a new value here must have no effect
            in_a = ~a;
            start = 1'b1;
            @(posedge clk);
            #DRIVE_DELAY;
            start = 1'b0;
        end
        do @(negedge clk); while (!done);
        r = result;
        // Long wait after a double start to catch a second run
        repeat (double_start ? 80 : 3) @(posedge clk);
        assert (done_count == dones_before + 1) else begin
            $display("FAILED at %0t: expected one done, saw %0d", $time,
                     done_count - dones_before);
            check_errors++;
        end
    endtask

    task automatic check_product(input operand_t a, input operand_t b, input operand_t m,
                                 input operand_t r);
        assert (result_matches(a, b, m, r)) else begin
            $display("FAILED at %0t: a=%h b=%h m=%h result=%h", $time, a, b, m, r);
            check_errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (check_errors == errors_before) begin
            pass_count++;
            $display("[%0t] %s: ok", $time, name);
        end else begin
            fail_count++;
            $display("[%0t] %s: wrong", $time, name);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        resetn = 1'b0;
        start = 1'b0;
        in_a = '0;
        in_b = '0;
        in_m = '0;
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        resetn = 1'b1;

        test_errors = check_errors;
        @(negedge clk);
        assert (!done && result == '0) else begin
            $display("FAILED at %0t: done or result not cleared by reset", $time);
            check_errors++;
        end
        report_test("reset state", test_errors);

        for (int i = 0; i < RANDOM_RUNS; i++) begin
            test_errors = check_errors;
            m = random_word() | 64'd1;
            if (m < 64'd3) begin
                m = 64'd3;
            end
            a = random_word() % m;
            b = random_word() % m;
            run_mult(a, b, m, 1'b0, r);
            check_product(a, b, m, r);
            report_test($sformatf("random run %0d", i), test_errors);
        end

        test_errors = check_errors;
        m = random_word() | 64'd1;
        run_mult(64'd0, random_word() % m, m, 1'b0, r);
        assert (r == '0) else begin
            $display("FAILED at %0t: a is zero but result=%h", $time, r);
            check_errors++;
        end
        report_test("zero a", test_errors);

        test_errors = check_errors;
        m = random_word() | 64'd1;
        run_mult(random_word() % m, 64'd0, m, 1'b0, r);
        assert (r == '0) else begin
            $display("FAILED at %0t: b is zero but result=%h", $time, r);
            check_errors++;
        end
        report_test("zero b", test_errors);

        test_errors = check_errors;
        m = 64'hffff_ffff_ffff_ffc5;
        run_mult(m - 64'd1, m - 64'd1, m, 1'b0, r);
        check_product(m - 64'd1, m - 64'd1, m, r);
        report_test("largest operands", test_errors);

        test_errors = check_errors;
        m = random_word() | 64'd1;
        a = random_word() % m;
        b = random_word() % m;
        run_mult(a, b, m, 1'b1, r);
        check_product(a, b, m, r);
        report_test("start while busy", test_errors);

        $display("Tests: %0d passed, %0d failed, %0d check errors",
                 pass_count, fail_count, check_errors);
        if (fail_count == 0 && check_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
logic/mont_pkg.sv
logic/mult_table_if.sv
logic/mont_control.sv
logic/digit_decode.sv
logic/mult_table.sv
logic/mont_accumulate.sv
logic/mont_reduce.sv
logic/mont_mult.sv
testbench/mont_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module mont_tb -o mont_sim || exit 1
out=$(./obj_dir/mont_sim)
echo "$out"
echo "$out" | grep -qx "Test passed" && exit 0 || exit 1
